// ==== source/phy_rate_pkg.sv ====
`default_nettype none

package phy_rate_pkg;

	localparam int DUR_W = 16;
	typedef logic [DUR_W-1:0] dur_t; // time in us

	typedef struct packed {
		logic       cck;
		logic       pad;
		logic [1:0] rate; // 1, 2, 5.5, 11
	} cck_code_t;

	typedef struct packed {
		logic       cck;
		logic [2:0] rate; // 6 .. 54 ascending
	} ofdm_code_t;

	// one rate code, read by family
	typedef union packed {
		cck_code_t  cck;
		ofdm_code_t ofdm;
	} rate_code_u;

	localparam int NUM_RATES = 12;
	localparam int NUM_CCK   = 4;

	typedef logic [3:0] rate_idx_t; // 0-3 cck, 4-11 ofdm
	typedef logic [NUM_RATES-1:0] basic_set_t;

	localparam rate_idx_t IDX_6M  = 4'd4;
	localparam rate_idx_t IDX_12M = 4'd6;
	localparam rate_idx_t IDX_24M = 4'd8;

	// cck rates in 0.5 Mb/s, element 0 is 1 Mb/s
	localparam logic [3:0][4:0] CCK_HALF_MBPS = {5'd22, 5'd11, 5'd4, 5'd2};
	// data bits per ofdm symbol, element 0 is 6 Mb/s
	localparam logic [7:0][7:0] OFDM_NDBPS =
		{8'd216, 8'd192, 8'd144, 8'd96, 8'd72, 8'd48, 8'd36, 8'd24};

	localparam dur_t CCK_LONG_PRE  = 16'd192;
	localparam dur_t CCK_SHORT_PRE = 16'd96;
	localparam dur_t OFDM_PREAMBLE = 16'd16;
	localparam dur_t OFDM_SIGNAL   = 16'd4;
	localparam dur_t OFDM_SYMBOL   = 16'd4;
	localparam dur_t DUR_CLAMP     = 16'd100;

	localparam int SERVICE_BITS = 16;
	localparam int TAIL_BITS    = 6;

endpackage

`default_nettype wire

// ==== source/resp_pipe_pkg.sv ====
`default_nettype none

package resp_pipe_pkg;

	import phy_rate_pkg::*;

	localparam int REQ_CREDITS = 2;
	localparam int RES_CREDITS = 2;

	localparam int REQ_PTR_W = $clog2(REQ_CREDITS);
	localparam int REQ_CNT_W = $clog2(REQ_CREDITS + 1);
	localparam int RES_CNT_W = $clog2(RES_CREDITS + 1);

	// serial divider sizing
	localparam int DIV_W  = 16;
	localparam int DEN_W  = 8;
	localparam int STEP_W = $clog2(DIV_W + 1);

	typedef struct packed {
		dur_t        mpdu_dur;
		dur_t        sifs;
		rate_code_u  rx_rate;
		basic_set_t  basic_set;
		logic [7:0]  resp_len;
		logic        long_pre;
	} resp_req_t;

	typedef struct packed {
		dur_t        mpdu_dur;
		dur_t        sifs;
		rate_code_u  resp_rate;
		logic [7:0]  resp_len;
		logic        long_pre;
	} rate_job_t;

	typedef struct packed {
		dur_t        mpdu_dur;
		dur_t        sifs;
		dur_t        air_time;
		rate_code_u  resp_rate; // carried on for the result
	} air_job_t;

	typedef struct packed {
		dur_t        dur_updated;
		rate_code_u  resp_rate;
	} resp_res_t;

endpackage

`default_nettype wire

// ==== source/resp_rate_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module resp_rate_decode import phy_rate_pkg::*, resp_pipe_pkg::*; (
	input  wire logic      clk,
	input  wire logic      rst,
	input  wire logic      req_valid,
	input  wire resp_req_t req,
	input  wire logic      job_ready,
	output logic           req_credit,
	output logic           job_valid,
	output rate_job_t      job
);

	resp_req_t buf_mem [REQ_CREDITS];
	logic [REQ_PTR_W-1:0] wr_ptr;
	logic [REQ_PTR_W-1:0] rd_ptr;
	logic [REQ_CNT_W-1:0] count;
	resp_req_t head;
	rate_idx_t rx_idx;
	rate_idx_t sel_idx;
	logic pop;

	function automatic logic [REQ_PTR_W-1:0] next_ptr(logic [REQ_PTR_W-1:0] p);
		return (p == REQ_PTR_W'(REQ_CREDITS - 1)) ? '0 : p + 1'b1;
	endfunction

	function automatic rate_idx_t code_to_idx(rate_code_u code);
		if (code.cck.cck)
			return rate_idx_t'(code.cck.rate);
		return rate_idx_t'(NUM_CCK + int'(code.ofdm.rate));
	endfunction

	// highest basic rate not above rx, same family
	function automatic rate_idx_t pick_rate(rate_idx_t rx, basic_set_t basic);
		rate_idx_t sel;
		logic found;
		logic rx_cck;
		sel = rx;
		found = 1'b0;
		rx_cck = int'(rx) < NUM_CCK;
		for (int i = 0; i < NUM_RATES; i++) begin
			if (basic[i] && i <= int'(rx) && ((i < NUM_CCK) == rx_cck)) begin
				sel = rate_idx_t'(i);
				found = 1'b1;
			end
		end
		if (!found && !rx_cck) begin
			if (rx < IDX_12M)
				sel = IDX_6M;
			else if (rx < IDX_24M)
				sel = IDX_12M;
			else
				sel = IDX_24M;
		end
		return sel; // cck without a match keeps rx
	endfunction

	function automatic rate_code_u idx_to_code(rate_idx_t idx);
		rate_code_u code;
		if (int'(idx) < NUM_CCK) begin
			code.cck.cck  = 1'b1;
			code.cck.pad  = 1'b0;
			code.cck.rate = idx[1:0];
		end else begin
			code.ofdm.cck  = 1'b0;
			code.ofdm.rate = 3'(int'(idx) - NUM_CCK);
		end
		return code;
	endfunction

	assign head       = buf_mem[rd_ptr];
	assign job_valid  = count != '0;
	assign pop        = job_valid && job_ready;
	assign req_credit = pop; // credit back on each pop
	assign rx_idx     = code_to_idx(head.rx_rate);
	assign sel_idx    = pick_rate(rx_idx, head.basic_set);

	always_comb begin
		job.mpdu_dur  = head.mpdu_dur;
		job.sifs      = head.sifs;
		job.resp_rate = idx_to_code(sel_idx);
		job.resp_len  = head.resp_len;
		job.long_pre  = head.long_pre;
	end

	always_ff @(posedge clk) begin
		if (req_valid)
			buf_mem[wr_ptr] <= req;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (req_valid)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			count <= count + REQ_CNT_W'(req_valid) - REQ_CNT_W'(pop);
		end
	end

endmodule

`default_nettype wire

// ==== source/frame_time_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_time_execute import phy_rate_pkg::*, resp_pipe_pkg::*; (
	input  wire logic      clk,
	input  wire logic      rst,
	input  wire logic      job_valid,
	input  wire rate_job_t job,
	input  wire logic      air_ready,
	output logic           job_ready,
	output logic           air_valid,
	output air_job_t       air
);

	rate_job_t job_q;
	air_job_t air_q;
	logic active;
	logic take;
	logic [STEP_W-1:0] step;
	logic [DIV_W-1:0] quo; // numerator shifts out, quotient shifts in
	logic [DEN_W-1:0] rem;
	logic [DEN_W-1:0] den;
	logic [DEN_W:0] shifted;
	logic [DIV_W-1:0] num_in;
	logic [DEN_W-1:0] den_in;
	dur_t q_ceil;

	assign job_ready = !active;
	assign take      = job_valid && job_ready;
	assign air       = air_q;
	assign shifted   = {rem, quo[DIV_W-1]};
	assign q_ceil    = dur_t'(quo) + dur_t'(rem != '0); // round up to whole units

	always_comb begin
		if (job.resp_rate.cck.cck) begin
			num_in = DIV_W'({job.resp_len, 4'b0000});
			den_in = DEN_W'(CCK_HALF_MBPS[job.resp_rate.cck.rate]);
		end else begin
			num_in = DIV_W'(SERVICE_BITS + 8 * int'(job.resp_len) + TAIL_BITS);
			den_in = OFDM_NDBPS[job.resp_rate.ofdm.rate];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			active    <= 1'b0;
			air_valid <= 1'b0;
			step      <= '0;
		end else if (take) begin
			active <= 1'b1;
			step   <= STEP_W'(DIV_W);
		end else if (step != '0) begin
			step <= step - 1'b1;
		end else if (active && !air_valid) begin
			air_valid <= 1'b1;
		end else if (air_valid && air_ready) begin
			air_valid <= 1'b0;
			active    <= 1'b0;
		end
	end

	// restoring divider, one quotient bit per cycle
	always_ff @(posedge clk) begin
		if (take) begin
			job_q <= job;
			quo   <= num_in;
			rem   <= '0;
			den   <= den_in;
		end else if (step != '0) begin
			if (shifted >= {1'b0, den}) begin
				rem <= DEN_W'(shifted - {1'b0, den});
				quo <= {quo[DIV_W-2:0], 1'b1};
			end else begin
				rem <= shifted[DEN_W-1:0];
				quo <= {quo[DIV_W-2:0], 1'b0};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (active && step == '0 && !air_valid) begin
			air_q.mpdu_dur  <= job_q.mpdu_dur;
			air_q.sifs      <= job_q.sifs;
			air_q.resp_rate <= job_q.resp_rate;
			if (job_q.resp_rate.cck.cck)
				air_q.air_time <= q_ceil + (job_q.long_pre ? CCK_LONG_PRE : CCK_SHORT_PRE);
			else
				air_q.air_time <= OFDM_PREAMBLE + OFDM_SIGNAL + OFDM_SYMBOL * q_ceil;
		end
	end

endmodule

`default_nettype wire

// ==== source/dur_field_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module dur_field_result import phy_rate_pkg::*, resp_pipe_pkg::*; (
	input  wire logic     clk,
	input  wire logic     rst,
	input  wire logic     air_valid,
	input  wire air_job_t air,
	input  wire logic     res_credit,
	output logic          air_ready,
	output logic          res_valid,
	output resp_res_t     res
);

	logic [RES_CNT_W-1:0] credits;
	logic send;
	logic signed [DUR_W+1:0] diff;
	resp_res_t res_q;

	assign air_ready = credits != '0; // stall until the consumer returns one
	assign send      = air_valid && air_ready;
	assign res       = res_q;

	// two guard bits keep the sign
	assign diff = $signed({2'b00, air.mpdu_dur}) - $signed({2'b00, air.air_time})
		- $signed({2'b00, air.sifs});

	always_ff @(posedge clk) begin
		if (rst) begin
			res_valid <= 1'b0;
			credits   <= RES_CNT_W'(RES_CREDITS);
		end else begin
			res_valid <= send;
			credits   <= credits - RES_CNT_W'(send) + RES_CNT_W'(res_credit);
		end
	end

	always_ff @(posedge clk) begin
		if (send) begin
			res_q.resp_rate <= air.resp_rate;
			if (diff < 0)
				res_q.dur_updated <= DUR_CLAMP;
			else
				res_q.dur_updated <= diff[DUR_W-1:0];
		end
	end

endmodule

`default_nettype wire

// ==== source/resp_dur_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module resp_dur_top import resp_pipe_pkg::*; (
	input  wire logic      clk,
	input  wire logic      rst,
	input  wire logic      req_valid,
	input  wire resp_req_t req,
	input  wire logic      res_credit,
	output logic           req_credit,
	output logic           res_valid,
	output resp_res_t      res
);

	logic      job_valid;
	logic      job_ready;
	rate_job_t job;
	logic      air_valid;
	logic      air_ready;
	air_job_t  air;

	resp_rate_decode u_decode (
		.clk        (clk),
		.rst        (rst),
		.req_valid  (req_valid),
		.req        (req),
		.job_ready  (job_ready),
		.req_credit (req_credit),
		.job_valid  (job_valid),
		.job        (job)
	);

	frame_time_execute u_execute (
		.clk       (clk),
		.rst       (rst),
		.job_valid (job_valid),
		.job       (job),
		.air_ready (air_ready),
		.job_ready (job_ready),
		.air_valid (air_valid),
		.air       (air)
	);

	dur_field_result u_result (
		.clk        (clk),
		.rst        (rst),
		.air_valid  (air_valid),
		.air        (air),
		.res_credit (res_credit),
		.air_ready  (air_ready),
		.res_valid  (res_valid),
		.res        (res)
	);

endmodule

`default_nettype wire

// ==== tb/resp_dur_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module resp_dur_asserts import resp_pipe_pkg::*; (
	input wire logic      clk,
	input wire logic      rst,
	input wire logic      req_credit,
	input wire logic      res_valid,
	input wire resp_res_t res,
	input wire logic      res_credit
);

	int fails = 0;
	int outstanding; // sent results not yet credited back

	always_ff @(posedge clk) begin
		if (rst)
			outstanding <= 0;
		else
			outstanding <= outstanding + int'(res_valid) - int'(res_credit);
	end

	quiet_after_reset: assert property (@(posedge clk) rst |=> (!req_credit && !res_valid))
		else begin
			fails++;
			$error("req_credit or res_valid high right after reset");
		end

	res_known: assert property (@(posedge clk) disable iff (rst) res_valid |-> !$isunknown(res))
		else begin
			fails++;
			$error("res has unknown bits while res_valid is high");
		end

	credit_bound: assert property (@(posedge clk) disable iff (rst) outstanding <= RES_CREDITS)
		else begin
			fails++;
			$error("more results outstanding than result credits");
		end

endmodule

`default_nettype wire

// ==== tb/resp_dur_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module resp_dur_tb import phy_rate_pkg::*, resp_pipe_pkg::*; ();

	logic      clk;
	logic      rst;
	logic      req_valid;
	resp_req_t req;
	logic      res_credit;
	logic      req_credit;
	logic      res_valid;
	resp_res_t res;

	integer    seed;
	resp_res_t exp_q[$];
	int        req_credits_held;
	int        to_send;
	int        sent;
	int        received;
	int        outstanding; // results seen but not credited back yet
	int        credit_pulses;
	bit        withhold;

	resp_dur_top UUT (
		.clk        (clk),
		.rst        (rst),
		.req_valid  (req_valid),
		.req        (req),
		.res_credit (res_credit),
		.req_credit (req_credit),
		.res_valid  (res_valid),
		.res        (res)
	);

	bind resp_dur_top resp_dur_asserts u_asserts (
		.clk        (clk),
		.rst        (rst),
		.req_credit (req_credit),
		.res_valid  (res_valid),
		.res        (res),
		.res_credit (res_credit)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %s expected %0d actual %0d", name, expected, actual);
			$display("TEST FAIL");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	task automatic fail_now(string what);
		$display("%s", what);
		$display("TEST FAIL");
		$fatal(1, "run stopped");
	endtask

	function automatic int ceil_div(int n, int d);
		return (n + d - 1) / d;
	endfunction

	// 6 .. 54 Mb/s, 4 us symbols
	function automatic int ofdm_bits_per_symbol(int i);
		int mbps;
		case (i)
			0: mbps = 6;
			1: mbps = 9;
			2: mbps = 12;
			3: mbps = 18;
			4: mbps = 24;
			5: mbps = 36;
			6: mbps = 48;
			default: mbps = 54;
		endcase
		return mbps * 4;
	endfunction

	function automatic resp_res_t expected_result(resp_req_t r);
		resp_res_t  m;
		logic [3:0] code;
		logic [3:0] exp_code;
		int         half_mbps [4];
		int         rx;
		int         lo;
		int         sel;
		int         air;
		int         diff;
		bit         found;
		half_mbps = '{2, 4, 11, 22};
		code = r.rx_rate;
		lo = code[3] ? 0 : 4;
		rx = code[3] ? int'(code[1:0]) : 4 + int'(code[2:0]);
		sel = rx;
		found = 1'b0;
		for (int i = rx; i >= lo; i--) begin
			if (!found && r.basic_set[i]) begin
				sel = i;
				found = 1'b1;
			end
		end
		if (!found && lo == 4)
			sel = (rx <= 5) ? 4 : ((rx <= 7) ? 6 : 8);
		if (sel < 4) begin
			air = ceil_div(16 * int'(r.resp_len), half_mbps[sel])
				+ int'(r.long_pre ? CCK_LONG_PRE : CCK_SHORT_PRE);
			exp_code = {2'b10, 2'(sel)};
		end else begin
			air = int'(OFDM_PREAMBLE) + int'(OFDM_SIGNAL) + int'(OFDM_SYMBOL)
				* ceil_div(SERVICE_BITS + 8 * int'(r.resp_len) + TAIL_BITS,
				ofdm_bits_per_symbol(sel - 4));
			exp_code = {1'b0, 3'(sel - 4)};
		end
		diff = int'(r.mpdu_dur) - air - int'(r.sifs);
		m.resp_rate = exp_code;
		m.dur_updated = (diff < 0) ? DUR_CLAMP : 16'(diff);
		return m;
	endfunction

	function automatic resp_req_t random_req();
		resp_req_t r;
		r.rx_rate  = 4'($random(seed));
		r.resp_len = 8'($random(seed));
		r.long_pre = 1'($random(seed));
		r.sifs     = (($random(seed) & 1) == 1) ? 16'd10 : 16'd16;
		case ($random(seed) & 3)
			0: r.basic_set = '0; // fallback only
			1: r.basic_set = 12'($random(seed)) & 12'h0a5;
			default: r.basic_set = 12'($random(seed));
		endcase
		if (($random(seed) & 3) == 0)
			r.mpdu_dur = 16'($random(seed) & 255); // too short, clamps
		else
			r.mpdu_dur = 16'($random(seed));
		return r;
	endfunction

	// sample at the falling edge, then drive the next inputs
	task automatic step_cycle();
		resp_res_t exp;
		@(negedge clk);
		if (UUT.u_asserts.fails != 0)
			fail_now("a bound assertion on the DUT ports failed");
		if (req_credit) begin
			credit_pulses++;
			req_credits_held++;
		end
		if (res_valid && exp_q.size() == 0) begin
			fail_now("a result arrived with no request outstanding");
		end else if (res_valid) begin
			exp = exp_q.pop_front();
			check($sformatf("resp_rate #%0d", received), 32'(exp.resp_rate), 32'(res.resp_rate));
			check($sformatf("dur_updated #%0d", received), 32'(exp.dur_updated),
				32'(res.dur_updated));
			received++;
			outstanding++;
		end
		check("outstanding results in range", 32'(1), 32'(outstanding <= RES_CREDITS));
		res_credit = 1'b0;
		req_valid  = 1'b0;
		if (!withhold && outstanding > 0 && ($random(seed) & 3) == 0) begin
			res_credit = 1'b1;
			outstanding--;
		end
		if (to_send > 0 && req_credits_held > 0 && ($random(seed) & 1) == 1) begin
			req = random_req();
			req_valid = 1'b1;
			exp_q.push_back(expected_result(req));
			req_credits_held--;
			to_send--;
			sent++;
		end
	endtask

	initial begin
		int waited;
		seed = 32'h74f4b35f;
		rst = 1'b1;
		req_valid = 1'b0;
		req = '0;
		res_credit = 1'b0;
		withhold = 1'b0;
		req_credits_held = REQ_CREDITS;
		to_send = 400;
		sent = 0;
		received = 0;
		outstanding = 0;
		credit_pulses = 0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		waited = 0;
		while (to_send > 0 || exp_q.size() > 0 || outstanding > 0) begin
			step_cycle();
			waited++;
			if (waited > 50000)
				fail_now("timeout waiting for the random traffic to drain");
		end

		// consumer holds its credits, pipeline backs up
		withhold = 1'b1;
		to_send = 6;
		waited = 0;
		while (outstanding < RES_CREDITS || exp_q.size() < REQ_CREDITS + 1) begin
			step_cycle();
			waited++;
			if (waited > 2000)
				fail_now("timeout waiting for the pipeline to fill without result credits");
		end
		repeat (100) step_cycle(); // fully stalled, nothing may move
		check("results while credits withheld", 32'(RES_CREDITS), 32'(outstanding));
		// decode buffer full plus the job parked in execute
		check("requests held in the pipe", 32'(REQ_CREDITS + 1), 32'(exp_q.size()));
		check("requests blocked at the producer", 32'(6 - RES_CREDITS - REQ_CREDITS - 1),
			32'(to_send));
		withhold = 1'b0;
		waited = 0;
		while (to_send > 0 || exp_q.size() > 0) begin
			step_cycle();
			waited++;
			if (waited > 2000)
				fail_now("timeout waiting for results after credits resumed");
		end
		check("req_credit pulses", 32'(sent), 32'(credit_pulses));

		if (UUT.u_asserts.fails != 0) begin
			$display("%0d assertion failures", UUT.u_asserts.fails);
			$display("TEST FAIL");
			$fatal(1, "assertions failed");
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== flist.f ====
source/phy_rate_pkg.sv
source/resp_pipe_pkg.sv
source/resp_rate_decode.sv
source/frame_time_execute.sv
source/dur_field_result.sv
source/resp_dur_top.sv
tb/resp_dur_asserts.sv
tb/resp_dur_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the resp_dur testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module resp_dur_tb \
	-Mdir obj_dir -o resp_dur_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/resp_dur_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAIL" sim.log; then
	echo "failure reported in sim.log"
	exit 1
fi
echo "no failure reported in sim.log"
exit 0
